// File: Bender.yml
package:
  name: adc_snapshot

sources:
  - include_dirs:
      - src
    files:
      - src/adc_sample_pkg.sv
      - src/snap_mem_pkg.sv
      - src/adc_lane_capture.sv
      - src/adc_sample_fifo.sv
      - src/snap_write_arbiter.sv
      - src/snap_buffer.sv
      - src/adc_snapshot_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_adc_snapshot.sv

// File: project.f
+incdir+src
src/adc_sample_pkg.sv
src/snap_mem_pkg.sv
src/adc_lane_capture.sv
src/adc_sample_fifo.sv
src/snap_write_arbiter.sv
src/snap_buffer.sv
src/adc_snapshot_top.sv
tb/tb_adc_snapshot.sv

// File: src/adc_config.svh
/*
 * ADC snapshot configuration
 * Design-wide depths and the optional input register stage
 */
`ifndef ADC_CONFIG_SVH
`define ADC_CONFIG_SVH

// Records held by each channel FIFO, power of two
`define ADC_FIFO_DEPTH 8
`define ADC_FIFO_AW $clog2(`ADC_FIFO_DEPTH)

// Records held by the snapshot buffer, power of two
`define ADC_SNAP_DEPTH 64
`define ADC_SNAP_AW $clog2(`ADC_SNAP_DEPTH)

// 1 adds a second register stage in front of the sample packer.
// Pins to rec_valid latency becomes two cycles instead of one
`define ADC_EXTRA_REG 0

`endif

// File: src/adc_lane_capture.sv
/*
 * ADC lane capture
 * Registers one board's deserialized lanes, packs them into a sample
 * word and swaps in a marker record on a rising sync
 */
`default_nettype none
`include "adc_config.svh"

module adc_lane_capture (
  input  logic                       adc_clk,
  input  logic                       mmcm_reset,
  input  logic                       arm,
  input  snap_mem_pkg::chan_id_t     chan,
  input  adc_sample_pkg::adc_lanes_t lanes,
  input  logic                       sample_valid,
  output snap_mem_pkg::snap_rec_t    rec,
  output logic                       rec_valid
);

  adc_sample_pkg::adc_lanes_t   lanes_s;
  logic                         valid_s;
  adc_sample_pkg::sample_word_t word;
  snap_mem_pkg::snap_rec_t      rec_next;
  logic [15:0]                  sample_cnt;
  logic [15:0]                  cnt_base;
  logic [3:0]                   prev_sync;
  logic                         sync_rise;
  logic [1:0]                   phase;

  generate
    if (`ADC_EXTRA_REG) begin : g_extra_reg
      adc_sample_pkg::adc_lanes_t lanes_q;
      logic                       valid_q;

      always_ff @(posedge adc_clk) begin
        lanes_q <= lanes;
        if (mmcm_reset) valid_q <= 1'b0;
        else valid_q <= sample_valid;
      end
      assign lanes_s = lanes_q;
      assign valid_s = valid_q;
    end else begin : g_direct
      assign lanes_s = lanes;
      assign valid_s = sample_valid;
    end
  endgenerate

  // Pack in the reference bit order
  assign word.sync       = lanes_s.sync;
  assign word.outofrange = {lanes_s.ovr_fall, lanes_s.ovr_rise};
  assign word.q = {lanes_s.dq_fall, lanes_s.dq_d_fall, lanes_s.dq_rise, lanes_s.dq_d_rise};
  assign word.i = {lanes_s.di_fall, lanes_s.di_d_fall, lanes_s.di_rise, lanes_s.di_d_rise};

  assign cnt_base  = arm ? 16'd0 : sample_cnt;  // Count restarts on the arm cycle
  assign sync_rise = (|word.sync) && !(|prev_sync);

  always_comb begin
    casez (word.sync)  // Earliest phase that saw sync
      4'b???1: phase = 2'd0;
      4'b??10: phase = 2'd1;
      4'b?100: phase = 2'd2;
      default: phase = 2'd3;
    endcase
  end

  always_comb begin
    rec_next.chan      = chan;
    rec_next.is_marker = sync_rise;
    rec_next.payload   = word;
    if (sync_rise) begin
      rec_next.payload.marker.pad   = '0;
      rec_next.payload.marker.count = cnt_base;
      rec_next.payload.marker.phase = phase;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (mmcm_reset) begin
      rec_valid  <= 1'b0;
      sample_cnt <= 16'd0;
      prev_sync  <= 4'd0;
    end else begin
      rec_valid <= valid_s;
      if (arm || valid_s) sample_cnt <= cnt_base + 16'(valid_s);
      if (valid_s) prev_sync <= word.sync;  // Edge is tracked across arms
    end
  end

  always_ff @(posedge adc_clk) rec <= rec_next;

  a_no_valid_after_reset: assert property (@(posedge adc_clk) mmcm_reset |=> !rec_valid)
    else $error("rec_valid high in the cycle after reset");

endmodule

`default_nettype wire

// File: src/adc_sample_fifo.sv
/*
 * Channel record FIFO
 * Synchronous circular buffer between a capture channel and the
 * write arbiter. Pushes into a full FIFO are dropped and counted
 */
`default_nettype none
`include "adc_config.svh"

module adc_sample_fifo (
  input  logic                    adc_clk,
  input  logic                    mmcm_reset,
  input  logic                    arm,
  input  snap_mem_pkg::snap_rec_t push_rec,
  input  logic                    push,
  input  logic                    pop,
  output snap_mem_pkg::snap_rec_t head_rec,
  output logic                    not_empty,
  output logic [15:0]             drop_count
);

  localparam int AW = `ADC_FIFO_AW;

  snap_mem_pkg::snap_rec_t mem [`ADC_FIFO_DEPTH];
  logic [AW-1:0]           wr_ptr;
  logic [AW-1:0]           rd_ptr;
  logic [AW:0]             level;
  logic                    full;
  logic                    do_push;
  logic                    do_pop;

  assign full      = (level == (AW+1)'(`ADC_FIFO_DEPTH));
  assign not_empty = (level != '0);
  assign do_push   = push && !full;
  assign do_pop    = pop && not_empty;
  assign head_rec  = mem[rd_ptr];

  always_ff @(posedge adc_clk) begin
    if (mmcm_reset || arm) begin  // Arm flushes whatever is queued
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      level      <= '0;
      drop_count <= 16'd0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
      if (push && full && drop_count != 16'hffff) drop_count <= drop_count + 16'd1;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (do_push) mem[wr_ptr] <= push_rec;
  end

  a_no_pop_empty: assert property (
    @(posedge adc_clk) disable iff (mmcm_reset) pop |-> not_empty)
    else $error("Pop on an empty FIFO");

endmodule

`default_nettype wire

// File: src/adc_sample_pkg.sv
/*
 * ADC sample types
 * Per-cycle lanes of one deserialized ADC board and the packed
 * 70-bit sample word built from them
 */
`default_nettype none

package adc_sample_pkg;

  // One board in one adc_clk cycle, after the DDR demux
  typedef struct packed {
    logic [3:0] sync;       // Sync sampled on the 0/90/180/270 phases
    logic       ovr_fall;
    logic       ovr_rise;
    logic [7:0] dq_fall;
    logic [7:0] dq_d_fall;
    logic [7:0] dq_rise;
    logic [7:0] dq_d_rise;   // Oldest Q sample of the cycle
    logic [7:0] di_fall;
    logic [7:0] di_d_fall;
    logic [7:0] di_rise;
    logic [7:0] di_d_rise;   // Oldest I sample of the cycle
  } adc_lanes_t;

  // Sample word as the capture path stores it
  // Sample 0 is the oldest, in the low byte of each channel
  typedef struct packed {
    logic [3:0]      sync;
    logic [1:0]      outofrange;  // Bit 0 rise, bit 1 fall
    logic [3:0][7:0] q;
    logic [3:0][7:0] i;
  } sample_word_t;

endpackage

`default_nettype wire

// File: src/adc_snapshot_top.sv
/*
 * ADC snapshot top level
 * Two capture channels, each with its own record FIFO, share the
 * snapshot buffer write port through a round-robin arbiter
 */
`default_nettype none
`include "adc_config.svh"

module adc_snapshot_top (
  input  logic                       adc_clk,
  input  logic                       mmcm_reset,
  input  logic                       arm,
  input  adc_sample_pkg::adc_lanes_t lanes0,
  input  adc_sample_pkg::adc_lanes_t lanes1,
  input  logic                       sample_valid0,
  input  logic                       sample_valid1,
  input  logic [`ADC_SNAP_AW-1:0]    rd_addr,
  output snap_mem_pkg::snap_rec_t    rd_rec,
  output logic                       snap_done,
  output logic [`ADC_SNAP_AW:0]      snap_count,
  output logic [15:0]                drop_count0,
  output logic [15:0]                drop_count1
);

  snap_mem_pkg::snap_rec_t rec0;
  snap_mem_pkg::snap_rec_t rec1;
  logic                    rec_valid0;
  logic                    rec_valid1;
  snap_mem_pkg::snap_rec_t head0;
  snap_mem_pkg::snap_rec_t head1;
  logic                    not_empty0;
  logic                    not_empty1;
  logic                    grant0;
  logic                    grant1;
  logic                    wr_en;
  snap_mem_pkg::snap_rec_t wr_rec;
  logic                    accepting;

  adc_lane_capture adc_lane_capture0_inst (.adc_clk(adc_clk), .mmcm_reset(mmcm_reset),
    .arm(arm), .chan(1'b0), .lanes(lanes0), .sample_valid(sample_valid0),
    .rec(rec0), .rec_valid(rec_valid0));

  adc_lane_capture adc_lane_capture1_inst (.adc_clk(adc_clk), .mmcm_reset(mmcm_reset),
    .arm(arm), .chan(1'b1), .lanes(lanes1), .sample_valid(sample_valid1),
    .rec(rec1), .rec_valid(rec_valid1));

  adc_sample_fifo adc_sample_fifo0_inst (.adc_clk(adc_clk), .mmcm_reset(mmcm_reset),
    .arm(arm), .push_rec(rec0), .push(rec_valid0), .pop(grant0),
    .head_rec(head0), .not_empty(not_empty0), .drop_count(drop_count0));

  adc_sample_fifo adc_sample_fifo1_inst (.adc_clk(adc_clk), .mmcm_reset(mmcm_reset),
    .arm(arm), .push_rec(rec1), .push(rec_valid1), .pop(grant1),
    .head_rec(head1), .not_empty(not_empty1), .drop_count(drop_count1));

  snap_write_arbiter snap_write_arbiter_inst (.adc_clk(adc_clk), .mmcm_reset(mmcm_reset),
    .accepting(accepting), .head0(head0), .head1(head1),
    .not_empty0(not_empty0), .not_empty1(not_empty1),
    .grant0(grant0), .grant1(grant1), .wr_en(wr_en), .wr_rec(wr_rec));

  snap_buffer snap_buffer_inst (.adc_clk(adc_clk), .mmcm_reset(mmcm_reset), .arm(arm),
    .wr_en(wr_en), .wr_rec(wr_rec), .rd_addr(rd_addr), .rd_rec(rd_rec),
    .accepting(accepting), .snap_done(snap_done), .snap_count(snap_count));

endmodule

`default_nettype wire

// File: src/snap_buffer.sv
/*
 * Snapshot buffer
 * Arm starts a capture, records are written in arrival order until
 * the memory is full, then snap_done holds until the next arm.
 * Read port is registered, one cycle from rd_addr to rd_rec
 */
`default_nettype none
`include "adc_config.svh"

module snap_buffer (
  input  logic                       adc_clk,
  input  logic                       mmcm_reset,
  input  logic                       arm,
  input  logic                       wr_en,
  input  snap_mem_pkg::snap_rec_t    wr_rec,
  input  logic [`ADC_SNAP_AW-1:0]    rd_addr,
  output snap_mem_pkg::snap_rec_t    rd_rec,
  output logic                       accepting,
  output logic                       snap_done,
  output logic [`ADC_SNAP_AW:0]      snap_count
);

  localparam int AW = `ADC_SNAP_AW;

  snap_mem_pkg::snap_rec_t mem [`ADC_SNAP_DEPTH];
  logic [AW-1:0]           wr_ptr;
  logic                    do_write;
  logic                    last_write;

  assign wr_ptr     = snap_count[AW-1:0];  // Fill level doubles as pointer
  assign do_write   = wr_en && accepting && !arm;
  assign last_write = do_write && (snap_count == (AW+1)'(`ADC_SNAP_DEPTH - 1));

  always_ff @(posedge adc_clk) begin
    if (mmcm_reset) begin
      accepting  <= 1'b0;
      snap_done  <= 1'b0;
      snap_count <= '0;
    end else if (arm) begin
      accepting  <= 1'b1;  // Restart from an empty buffer
      snap_done  <= 1'b0;
      snap_count <= '0;
    end else if (do_write) begin
      snap_count <= snap_count + 1'b1;
      if (last_write) begin
        accepting <= 1'b0;
        snap_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (do_write) mem[wr_ptr] <= wr_rec;
  end

  always_ff @(posedge adc_clk) rd_rec <= mem[rd_addr];

  a_write_when_accepting: assert property (
    @(posedge adc_clk) disable iff (mmcm_reset) wr_en |-> accepting)
    else $error("Write while the buffer is not accepting");

endmodule

`default_nettype wire

// File: src/snap_mem_pkg.sv
/*
 * Snapshot storage types
 * A stored record carries the channel id, a marker tag and a 70-bit
 * payload read either as sample data or as a sync marker
 */
`default_nettype none

package snap_mem_pkg;

  // Channel number, 0 or 1
  typedef logic chan_id_t;

  // Sync marker, stands in for the word on which sync rose
  typedef struct packed {
    logic [$bits(adc_sample_pkg::sample_word_t)-19:0] pad;  // Zero
    logic [15:0]                                      count;
    logic [1:0]                                       phase;
  } marker_t;

  // Payload decode depends on is_marker
  typedef union packed {
    adc_sample_pkg::sample_word_t data;
    marker_t                      marker;
  } snap_payload_u;

  typedef struct packed {
    chan_id_t      chan;
    logic          is_marker;
    snap_payload_u payload;
  } snap_rec_t;

endpackage

`default_nettype wire

// File: src/snap_write_arbiter.sv
/*
 * Snapshot write arbiter
 * Round-robin grant of the single buffer write port to the two
 * channel FIFOs. The granted FIFO pops in the grant cycle
 */
`default_nettype none

module snap_write_arbiter (
  input  logic                    adc_clk,
  input  logic                    mmcm_reset,
  input  logic                    accepting,
  input  snap_mem_pkg::snap_rec_t head0,
  input  snap_mem_pkg::snap_rec_t head1,
  input  logic                    not_empty0,
  input  logic                    not_empty1,
  output logic                    grant0,
  output logic                    grant1,
  output logic                    wr_en,
  output snap_mem_pkg::snap_rec_t wr_rec
);

  logic prio1;  // Channel 1 wins the next conflict

  always_comb begin
    grant0 = 1'b0;
    grant1 = 1'b0;
    if (accepting) begin
      if (not_empty0 && (!not_empty1 || !prio1)) grant0 = 1'b1;
      else if (not_empty1) grant1 = 1'b1;
    end
  end

  assign wr_en  = grant0 || grant1;
  assign wr_rec = grant1 ? head1 : head0;

  // Priority flips to the other channel after every grant
  always_ff @(posedge adc_clk) begin
    if (mmcm_reset) begin
      prio1 <= 1'b0;
    end else if (grant0) begin
      prio1 <= 1'b1;
    end else if (grant1) begin
      prio1 <= 1'b0;
    end
  end

  a_one_grant: assert property (@(posedge adc_clk) disable iff (mmcm_reset)
    !(grant0 && grant1))
    else $error("Both channels granted");

endmodule

`default_nettype wire

// File: tb/tb_adc_snapshot.sv
/*
 * Testbench for the ADC snapshot top level
 * Random lanes and sync pulses from an xorshift generator feed both
 * channels. A per-channel model builds the expected records, and the
 * buffer is read back after each capture and compared with it
 */
`default_nettype none
`include "adc_config.svh"

module tb_adc_snapshot;

  localparam int LIGHT_WORDS   = 40;
  localparam int PREARM_CYCLES = 20;
  localparam int EXP_MAX       = 256;
  localparam int DRAIN_MAX     = 2 * `ADC_FIFO_DEPTH + 16;
  localparam int ARM_CYC       = 8;
  localparam int LIGHT_CYC     = LIGHT_WORDS * 6 + DRAIN_MAX + LIGHT_WORDS + 16;
  localparam int SAT_CYC       = 3 * `ADC_SNAP_DEPTH + 16;
  localparam int MAX_CYCLES    = PREARM_CYCLES + 2 + 4 * ARM_CYC + 3 * LIGHT_CYC + SAT_CYC;

  logic                       adc_clk;
  logic                       mmcm_reset;
  logic                       arm;
  adc_sample_pkg::adc_lanes_t lanes0;
  adc_sample_pkg::adc_lanes_t lanes1;
  logic                       sample_valid0;
  logic                       sample_valid1;
  logic [`ADC_SNAP_AW-1:0]    rd_addr;
  snap_mem_pkg::snap_rec_t    rd_rec;
  logic                       snap_done;
  logic [`ADC_SNAP_AW:0]      snap_count;
  logic [15:0]                drop_count0;
  logic [15:0]                drop_count1;

  logic [31:0]             rng_state = 32'd29;
  int                      cycles = 0;
  int                      errors;
  int                      markers;   // Markers built by the model since arm
  logic [3:0]              prev_sync [2];
  logic [15:0]             word_cnt [2];
  int                      sync_left [2];
  int                      offered [2];
  int                      got_n [2];
  snap_mem_pkg::snap_rec_t exp_rec [2][EXP_MAX];
  snap_mem_pkg::snap_rec_t got_rec [2][EXP_MAX];

  adc_snapshot_top adc_snapshot_top_inst (
    .adc_clk(adc_clk), .mmcm_reset(mmcm_reset), .arm(arm),
    .lanes0(lanes0), .lanes1(lanes1),
    .sample_valid0(sample_valid0), .sample_valid1(sample_valid1),
    .rd_addr(rd_addr), .rd_rec(rd_rec), .snap_done(snap_done), .snap_count(snap_count),
    .drop_count0(drop_count0), .drop_count1(drop_count1)
  );

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Pulse of 1 to 3 phases, may run over into phase 0 of the next cycle
  function automatic logic [3:0] next_sync(input int ch, input bit en);
    logic [3:0] bits;
    int         p;
    int         w;
    bits = 4'd0;
    if (sync_left[ch] > 0) begin
      bits = 4'((1 << sync_left[ch]) - 1);
      sync_left[ch] = 0;
    end else if (en && (xorshift32() % 4 == 0)) begin
      p = xorshift32() % 4;
      w = 1 + xorshift32() % 3;
      for (int k = 0; k < w; k++) begin
        if (p + k < 4) bits[p + k] = 1'b1;
        else sync_left[ch]++;
      end
    end
    return bits;
  endfunction

  function automatic logic [1:0] lowest_phase(input logic [3:0] s);
    logic [1:0] ph;
    ph = 2'd0;
    for (int k = 3; k >= 0; k--) begin
      if (s[k]) ph = 2'(k);  // Last hit is the earliest phase
    end
    return ph;
  endfunction

  task automatic compare_value(input string name, input logic [71:0] expected,
                               input logic [71:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s: expected %h actual %h", name, expected, actual);
    end
  endtask

  // Expected record for one valid word, marker on a rising sync
  task automatic model_word(input int ch, input adc_sample_pkg::adc_lanes_t l);
    snap_mem_pkg::snap_rec_t r;
    r = '0;
    r.chan = (ch == 1);
    if (l.sync != 4'd0 && prev_sync[ch] == 4'd0) begin
      r.is_marker            = 1'b1;
      r.payload.marker.count = word_cnt[ch];
      r.payload.marker.phase = lowest_phase(l.sync);
      markers++;
    end else begin
      r.payload.data.sync          = l.sync;
      r.payload.data.outofrange[0] = l.ovr_rise;
      r.payload.data.outofrange[1] = l.ovr_fall;
      r.payload.data.i[0] = l.di_d_rise;  // Oldest sample first
      r.payload.data.i[1] = l.di_rise;
      r.payload.data.i[2] = l.di_d_fall;
      r.payload.data.i[3] = l.di_fall;
      r.payload.data.q[0] = l.dq_d_rise;
      r.payload.data.q[1] = l.dq_rise;
      r.payload.data.q[2] = l.dq_d_fall;
      r.payload.data.q[3] = l.dq_fall;
    end
    prev_sync[ch] = l.sync;
    word_cnt[ch]++;
    if (offered[ch] < EXP_MAX) begin
      exp_rec[ch][offered[ch]] = r;
      offered[ch]++;
    end else begin
      errors++;
      $display("Model record store full on channel %0d", ch);
    end
  endtask

  // One input cycle, each channel valid with pct percent while room lasts
  task automatic drive_cycle(input int pct, input bit sync_en, inout int room);
    adc_sample_pkg::adc_lanes_t l [2];
    logic                       v [2];
    logic [95:0]                rnd;
    for (int ch = 0; ch < 2; ch++) begin
      rnd          = {xorshift32(), xorshift32(), xorshift32()};
      l[ch]        = '0;
      l[ch][65:0]  = rnd[65:0];  // All samples and both over-range bits
      l[ch].sync   = next_sync(ch, sync_en);
      v[ch]        = (room > 0) && (xorshift32() % 100 < pct);
      if (v[ch]) begin
        room--;
        model_word(ch, l[ch]);
      end
    end
    @(posedge adc_clk);
    lanes0        <= l[0];
    lanes1        <= l[1];
    sample_valid0 <= v[0];
    sample_valid1 <= v[1];
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge adc_clk);
      sample_valid0 <= 1'b0;
      sample_valid1 <= 1'b0;
    end
  endtask

  task automatic arm_capture(input string name);
    drive_idle(3);  // Let words in flight settle before the flush
    @(posedge adc_clk);
    arm <= 1'b1;
    @(posedge adc_clk);
    arm <= 1'b0;
    @(negedge adc_clk);
    compare_value({name, " snap_count"}, 0, snap_count);
    compare_value({name, " snap_done"}, 0, snap_done);
    compare_value({name, " drop_count0"}, 0, drop_count0);
    compare_value({name, " drop_count1"}, 0, drop_count1);
    for (int ch = 0; ch < 2; ch++) begin
      word_cnt[ch] = 16'd0;  // prev_sync survives the arm
      offered[ch]  = 0;
      got_n[ch]    = 0;
    end
    markers = 0;
  endtask

  // Registered read port, record for address a shows one cycle later
  task automatic read_buffer(input int n);
    snap_mem_pkg::snap_rec_t r;
    for (int a = 0; a <= n; a++) begin
      @(posedge adc_clk);
      if (a < n) rd_addr <= a[`ADC_SNAP_AW-1:0];
      @(negedge adc_clk);
      if (a > 0) begin
        r = rd_rec;
        got_rec[r.chan][got_n[r.chan]] = r;
        got_n[r.chan]++;
      end
    end
  endtask

  task automatic light_capture(input string name, input int pct, input bit sync_en);
    int room;
    int total;
    int waited;
    room = LIGHT_WORDS;
    while (room > 0) drive_cycle(pct, sync_en, room);
    total  = offered[0] + offered[1];
    waited = 0;
    drive_idle(1);
    @(negedge adc_clk);
    while (snap_count != total && waited < DRAIN_MAX) begin
      @(negedge adc_clk);
      waited++;
    end
    if (snap_count != total) begin
      errors++;
      $display("%s: buffer did not reach %0d records within %0d cycles", name, total, waited);
    end
    drive_idle(4);  // No late writes may follow
    @(negedge adc_clk);
    compare_value({name, " snap_count"}, total, snap_count);
    compare_value({name, " drop_count0"}, 0, drop_count0);
    compare_value({name, " drop_count1"}, 0, drop_count1);
    read_buffer(total);
    for (int ch = 0; ch < 2; ch++) begin
      compare_value($sformatf("%s ch%0d records", name, ch), offered[ch], got_n[ch]);
      for (int k = 0; k < offered[ch] && k < got_n[ch]; k++) begin
        compare_value($sformatf("%s ch%0d rec %0d", name, ch, k),
                      exp_rec[ch][k], got_rec[ch][k]);
      end
    end
  endtask

  task automatic saturation_capture();
    int room;
    int pos;
    int drops;
    room = EXP_MAX;
    while (!snap_done) begin
      drive_cycle(100, 1'b1, room);
      @(negedge adc_clk);
    end
    drive_idle(4);
    @(negedge adc_clk);
    compare_value("saturation snap_count", `ADC_SNAP_DEPTH, snap_count);
    compare_value("saturation snap_done", 1, snap_done);
    read_buffer(`ADC_SNAP_DEPTH);
    for (int ch = 0; ch < 2; ch++) begin
      pos   = 0;
      drops = (ch == 0) ? drop_count0 : drop_count1;
      for (int k = 0; k < got_n[ch]; k++) begin
        while (pos < offered[ch] && exp_rec[ch][pos] !== got_rec[ch][k]) pos++;
        if (pos == offered[ch]) begin
          errors++;
          $display("saturation: ch%0d stored record %0d is out of order or unknown", ch, k);
          break;
        end
        pos++;
      end
      if (got_n[ch] + drops > offered[ch]) begin
        errors++;
        $display("saturation: ch%0d stored %0d plus dropped %0d exceeds %0d offered words",
                 ch, got_n[ch], drops, offered[ch]);
      end
    end
  endtask

  initial begin : main
    int room;
    errors        = 0;
    markers       = 0;
    mmcm_reset    = 1'b1;
    arm           = 1'b0;
    lanes0        = '0;
    lanes1        = '0;
    sample_valid0 = 1'b0;
    sample_valid1 = 1'b0;
    rd_addr       = '0;
    for (int ch = 0; ch < 2; ch++) begin
      prev_sync[ch] = 4'd0;
      word_cnt[ch]  = 16'd0;
      sync_left[ch] = 0;
      offered[ch]   = 0;
      got_n[ch]     = 0;
    end
    repeat (2) @(posedge adc_clk);
    mmcm_reset <= 1'b0;

    // Inputs toggle before the first arm, the buffer must stay empty
    room = EXP_MAX;
    repeat (PREARM_CYCLES) begin
      drive_cycle(50, 1'b1, room);
      @(negedge adc_clk);
      compare_value("reset snap_count", 0, snap_count);
      compare_value("reset snap_done", 0, snap_done);
    end

    arm_capture("arm light");
    light_capture("light", 30, 1'b0);
    arm_capture("arm sync");
    light_capture("sync", 30, 1'b1);
    if (markers == 0) begin
      errors++;
      $display("sync: stimulus produced no marker records");
    end
    arm_capture("arm saturation");
    saturation_capture();
    arm_capture("rearm");
    light_capture("rearm", 30, 1'b1);

    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
